// ==== hdl/apbCommandPort.sv ====
// --------------------
// APB slave for the heap
// Decodes paddr, ranks unit errors, commits, registers the response
// --------------------
`timescale 1ns/10ps

module apbCommandPort import heapPkg::*; #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2,
  parameter int dataBits    = 12
) (
  input  logic                                        clock,
  input  logic                                        resetN,
  input  logic                                        psel,
  input  logic                                        penable,
  input  logic [actionBits+addressBits+indexBits-1:0] paddr,
  input  logic [dataBits-1:0]                         pwdata,
  output logic [dataBits-1:0]                         prdata,
  output logic                                        pready,
  output logic                                        pslverr,
  heapOpIf.command                                    op
);

  logic                knownAction;                  // Code is one we implement
  heapError            cmdError;                     // Winning error
  logic [dataBits-1:0] result;                       // Result on success

  // --------------------
  // Command decode
  // --------------------
  assign op.action  = heapAction'(paddr[actionBits+addressBits+indexBits-1 -: actionBits]);
  assign op.array   = paddr[indexBits +: addressBits];
  assign op.index   = paddr[indexBits-1:0];
  assign op.operand = pwdata;
  assign op.valid   = psel & penable & ~pready;      // Wait state not yet given
  assign op.commit  = op.valid & (cmdError == errNone);

  always_comb begin
    case (op.action)
      actClear, actWrite, actRead, actSize, actPush, actPop, actResize,
      actAlloc, actFree, actAdd, actSub, actAnd, actOr, actXor: knownAction = 1'b1;
      default: knownAction = 1'b0;
    endcase
  end

  // Bad action, then liveness, then size, then out of memory
  always_comb begin
    if (!knownAction) begin
      cmdError = errBadAction;
    end else if (op.liveError == errNotAllocated || op.liveError == errFreed) begin
      cmdError = op.liveError;
    end else if (op.sizeError != errNone) begin
      cmdError = op.sizeError;
    end else begin
      cmdError = op.liveError;                       // errNoMemory or none
    end
  end

  // --------------------
  // Result select
  // --------------------
  always_comb begin
    case (op.action)
      actAlloc:        result = dataBits'(op.newArray);
      actSize:         result = dataBits'(op.curSize);
      actRead, actPop: result = op.elementData;      // Pop gives the removed element
      actWrite, actAdd, actSub, actAnd, actOr, actXor:
        result = op.updateData;                      // Written or new value
      default:         result = '0;                  // Clear, Free, Push, Resize
    endcase
  end

  // Response shows up one cycle after the first access cycle
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else begin
      pready  <= op.valid;
      pslverr <= op.valid & (cmdError != errNone);
    end
  end

  always_ff @(posedge clock) begin
    if (op.valid) begin
      prdata <= (cmdError != errNone) ? dataBits'(cmdError) : result;
    end
  end

endmodule

// ==== hdl/arrayAllocator.sv ====
// --------------------
// Array allocator
// Allocated count, live bits and a stack of freed arrays
// --------------------
`timescale 1ns/10ps

module arrayAllocator import heapPkg::*; #(
  parameter int addressBits = 2
) (
  input  logic        clock,
  input  logic        resetN,
  heapOpIf.allocator  op
);

  localparam int arrayCount = 2**addressBits;

  logic [addressBits:0]   allocCount;                // Arrays ever handed out
  logic [arrayCount-1:0]  live;                      // Allocated and not freed
  logic [addressBits-1:0] freed [arrayCount];        // Freed array stack
  logic [addressBits:0]   freedTop;                  // Entries on the stack
  logic [addressBits-1:0] topSlot;                   // Slot of the newest entry
  logic                   haveFreed;
  logic                   noMemory;

  assign haveFreed   = freedTop != '0;
  assign topSlot     = freedTop[addressBits-1:0] - 1'b1;
  assign noMemory    = !haveFreed && allocCount == (addressBits+1)'(arrayCount);
  assign op.newArray = haveFreed ? freed[topSlot] : allocCount[addressBits-1:0];  // Reuse first
  assign op.arrayLive = live[op.array];

  always_comb begin
    case (op.action)
      actClear: op.liveError = errNone;              // Needs no array
      actAlloc: op.liveError = noMemory ? errNoMemory : errNone;
      default: begin
        if ({1'b0, op.array} >= allocCount) begin
          op.liveError = errNotAllocated;
        end else if (!live[op.array]) begin
          op.liveError = errFreed;                   // Also refuses a second free
        end else begin
          op.liveError = errNone;
        end
      end
    endcase
  end

  // --------------------
  // Update on commit
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocCount <= '0;
      live       <= '0;
      freedTop   <= '0;
    end else if (op.commit) begin
      case (op.action)
        actClear: begin
          allocCount <= '0;
          live       <= '0;
          freedTop   <= '0;                          // Stack contents become stale
        end
        actAlloc: begin
          if (haveFreed) begin
            freedTop <= freedTop - 1'b1;
          end else begin
            allocCount <= allocCount + 1'b1;
          end
          live[op.newArray] <= 1'b1;
        end
        actFree: begin
          freedTop        <= freedTop + 1'b1;
          live[op.array]  <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (op.commit && op.action == actFree) begin
      freed[freedTop[addressBits-1:0]] <= op.array;  // Push onto stack
    end
  end

endmodule

// ==== hdl/arraySizeTable.sv ====
// --------------------
// Array size table
// One size per array and the bounds checks that depend on it
// --------------------
`timescale 1ns/10ps

module arraySizeTable import heapPkg::*; #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2,
  parameter int dataBits    = 12
) (
  input  logic    clock,
  input  logic    resetN,
  heapOpIf.sizes  op
);

  localparam int arrayCount  = 2**addressBits;
  localparam int arrayLength = 2**indexBits;
  localparam logic [indexBits:0] fullSize = (indexBits+1)'(arrayLength);

  logic [indexBits:0] sizes [arrayCount];            // 0 up to arrayLength
  logic [indexBits:0] nextIndex;                     // Index plus one
  logic               beyondSize;
  logic               tooLarge;

  assign op.curSize = sizes[op.array];
  assign nextIndex  = {1'b0, op.index} + 1'b1;
  assign beyondSize = {1'b0, op.index} >= op.curSize;
  assign tooLarge   = op.operand > dataBits'(arrayLength);

  // Size checks only mean something for a live array
  always_comb begin
    op.sizeError = errNone;
    if (op.arrayLive) begin
      case (op.action)
        actRead, actAdd, actSub, actAnd, actOr, actXor: begin
          if (beyondSize) op.sizeError = errOutOfBounds;
        end
        actPush: begin
          if (op.curSize == fullSize) op.sizeError = errFull;
        end
        actPop: begin
          if (op.curSize == '0) op.sizeError = errEmpty;
        end
        actResize: begin
          if (tooLarge) op.sizeError = errTooLarge;
        end
        default: ;
      endcase
    end
  end

  // --------------------
  // Update on commit
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < arrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else if (op.commit) begin
      case (op.action)
        actWrite: begin
          if (nextIndex > op.curSize) sizes[op.array] <= nextIndex;  // Grow only
        end
        actPush:   sizes[op.array]    <= op.curSize + 1'b1;
        actPop:    sizes[op.array]    <= op.curSize - 1'b1;
        actResize: sizes[op.array]    <= op.operand[indexBits:0];
        actAlloc:  sizes[op.newArray] <= '0;         // Fresh array starts empty
        default: ;
      endcase
    end
  end

endmodule

// ==== hdl/elementStore.sv ====
// --------------------
// Element store
// Element memory, slot select and the read-modify-write ALU
// --------------------
`timescale 1ns/10ps

module elementStore import heapPkg::*; #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2,
  parameter int dataBits    = 12
) (
  input  logic    clock,
  heapOpIf.store  op
);

  localparam int arrayCount  = 2**addressBits;
  localparam int arrayLength = 2**indexBits;

  logic [dataBits-1:0]  mem [arrayCount][arrayLength];  // Fixed block per array
  logic [indexBits-1:0] slot;                        // Element being touched
  logic                 writeSlot;

  always_comb begin
    case (op.action)
      actPush: slot = op.curSize[indexBits-1:0];     // One past the top
      actPop:  slot = op.curSize[indexBits-1:0] - 1'b1;  // Current top
      default: slot = op.index;
    endcase
  end

  assign op.elementData = mem[op.array][slot];

  // ALU, results wrap at dataBits
  always_comb begin
    case (op.action)
      actAdd:  op.updateData = op.elementData + op.operand;
      actSub:  op.updateData = op.elementData - op.operand;
      actAnd:  op.updateData = op.elementData & op.operand;
      actOr:   op.updateData = op.elementData | op.operand;
      actXor:  op.updateData = op.elementData ^ op.operand;
      default: op.updateData = op.operand;           // Write and Push
    endcase
  end

  always_comb begin
    case (op.action)
      actWrite, actPush, actAdd, actSub, actAnd, actOr, actXor: writeSlot = op.commit;
      default: writeSlot = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (writeSlot) begin
      mem[op.array][slot] <= op.updateData;
    end
  end

endmodule

// ==== hdl/heapMemory.sv ====
// --------------------
// Heap memory for fixed-size arrays
// APB slave in front of allocator, size table and element store
// --------------------
`timescale 1ns/10ps

module heapMemory import heapPkg::*; #(
  parameter int addressBits = 2,                     // Bits of array number
  parameter int indexBits   = 2,                     // Bits of element index
  parameter int dataBits    = 12                     // Element width
) (
  input  logic                                      clock,
  input  logic                                      resetN,
  input  logic                                      psel,
  input  logic                                      penable,
  input  logic                                      pwrite,  // Not decoded, every transfer is a command
  input  logic [actionBits+addressBits+indexBits-1:0] paddr,
  input  logic [dataBits-1:0]                       pwdata,
  output logic [dataBits-1:0]                       prdata,
  output logic                                      pready,
  output logic                                      pslverr
);

  heapOpIf #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits)) op ();

  apbCommandPort #(
    .addressBits(addressBits),
    .indexBits  (indexBits),
    .dataBits   (dataBits)
  ) commandPort0 (
    .clock  (clock),
    .resetN (resetN),
    .psel   (psel),
    .penable(penable),
    .paddr  (paddr),
    .pwdata (pwdata),
    .prdata (prdata),
    .pready (pready),
    .pslverr(pslverr),
    .op     (op.command)
  );

  arrayAllocator #(.addressBits(addressBits)) allocator0 (
    .clock (clock),
    .resetN(resetN),
    .op    (op.allocator)
  );

  arraySizeTable #(
    .addressBits(addressBits),
    .indexBits  (indexBits),
    .dataBits   (dataBits)
  ) sizeTable0 (
    .clock (clock),
    .resetN(resetN),
    .op    (op.sizes)
  );

  elementStore #(
    .addressBits(addressBits),
    .indexBits  (indexBits),
    .dataBits   (dataBits)
  ) store0 (
    .clock(clock),
    .op   (op.store)
  );

endmodule

// ==== hdl/heapOpIf.sv ====
// --------------------
// Heap command bundle
// One decoded command out to the units, their answers back
// --------------------
`timescale 1ns/10ps

interface heapOpIf import heapPkg::*; #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2,
  parameter int dataBits    = 12
);

  logic                   valid;                     // First access cycle of a transfer
  heapAction              action;
  logic [addressBits-1:0] array;
  logic [indexBits-1:0]   index;
  logic [dataBits-1:0]    operand;                   // pwdata
  logic                   commit;                    // Valid and no error, units update
  logic                   arrayLive;                 // Addressed array allocated, not freed
  heapError               liveError;
  logic [addressBits-1:0] newArray;                  // Candidate for Alloc
  logic [indexBits:0]     curSize;                   // Size of addressed array
  heapError               sizeError;
  logic [dataBits-1:0]    elementData;               // Content of selected slot
  logic [dataBits-1:0]    updateData;                // Value to store in that slot

  modport command (output valid, action, array, index, operand, commit,
                   input liveError, sizeError, newArray, curSize, elementData, updateData);
  modport allocator (input action, array, commit,
                     output arrayLive, liveError, newArray);
  modport sizes (input action, array, index, operand, commit, newArray, arrayLive,
                 output curSize, sizeError);
  modport store (input action, array, index, operand, commit, curSize,
                 output elementData, updateData);

endinterface

// ==== hdl/heapPkg.sv ====
// --------------------
// Heap memory shared definitions
// Command codes, error codes and the width of the action field
// --------------------
package heapPkg;

  localparam int actionBits = 5;                     // Action field at the top of paddr

  // --------------------
  // Command codes
  // --------------------
  typedef enum logic [actionBits-1:0] {
    actClear  = 5'd1,                                // Forget all arrays
    actWrite  = 5'd2,                                // Write element, may grow size
    actRead   = 5'd3,                                // Read element
    actSize   = 5'd4,                                // Current size of array
    actPush   = 5'd14,                               // Append at the top
    actPop    = 5'd15,                               // Remove from the top
    actResize = 5'd17,                               // Set size directly
    actAlloc  = 5'd18,                               // Hand out an array
    actFree   = 5'd19,                               // Give an array back
    actAdd    = 5'd20,                               // Element plus operand
    actSub    = 5'd22,                               // Element minus operand
    actOr     = 5'd28,                               // Bitwise or
    actXor    = 5'd29,                               // Bitwise xor
    actAnd    = 5'd30                                // Bitwise and
  } heapAction;

  // --------------------
  // Error codes on prdata
  // --------------------
  typedef enum logic [3:0] {
    errNone         = 4'd0,
    errNotAllocated = 4'd1,                          // Array number past allocated count
    errFreed        = 4'd2,                          // Array was freed
    errOutOfBounds  = 4'd3,                          // Index at or past size
    errFull         = 4'd4,                          // Push on full array
    errEmpty        = 4'd5,                          // Pop on empty array
    errTooLarge     = 4'd6,                          // Resize past array length
    errNoMemory     = 4'd7,                          // No array left to hand out
    errBadAction    = 4'd8                           // Unknown command code
  } heapError;

endpackage

// ==== project.f ====
+incdir+verif
hdl/heapPkg.sv
hdl/heapOpIf.sv
hdl/apbCommandPort.sv
hdl/arrayAllocator.sv
hdl/arraySizeTable.sv
hdl/elementStore.sv
hdl/heapMemory.sv
verif/heapMemoryTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the heap memory testbench with Verilator and run it.
# The exit status is the simulator's, so a failing run returns non-zero.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal -f project.f \
    --top-module heapMemoryTb -Mdir build; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./build/VheapMemoryTb; then
  echo "Simulation failed"
  exit 1
fi

echo "Simulation passed"
exit 0

// ==== verif/heapVectors.svh ====
// --------------------
// Heap command vectors
// Columns: action, array, index, pwdata, expected prdata, expected error
// --------------------
`ifndef HEAP_VECTORS_SVH
`define HEAP_VECTORS_SVH

task automatic buildTable();
  // Allocation order, reuse of a freed array
  addEntry(actAlloc,  0, 0, 12'h000, 12'h000, errNone);
  addEntry(actAlloc,  0, 0, 12'h000, 12'h001, errNone);
  addEntry(actAlloc,  0, 0, 12'h000, 12'h002, errNone);
  addEntry(actAlloc,  0, 0, 12'h000, 12'h003, errNone);
  addEntry(actAlloc,  0, 0, 12'h000, 12'h000, errNoMemory);  // All four in use
  addEntry(actFree,   2, 0, 12'h000, 12'h000, errNone);
  addEntry(actAlloc,  0, 0, 12'h000, 12'h002, errNone);      // Comes off the freed stack
  // Write, read and size on array 0
  addEntry(actWrite,  0, 0, 12'h123, 12'h123, errNone);
  addEntry(actWrite,  0, 2, 12'h456, 12'h456, errNone);
  addEntry(actSize,   0, 0, 12'h000, 12'h003, errNone);      // Grown to index plus one
  addEntry(actRead,   0, 0, 12'h000, 12'h123, errNone);
  addEntry(actRead,   0, 2, 12'h000, 12'h456, errNone);
  addEntry(actRead,   0, 3, 12'h000, 12'h000, errOutOfBounds);
  addEntry(actResize, 0, 0, 12'h005, 12'h000, errTooLarge);
  addEntry(actSize,   0, 0, 12'h000, 12'h003, errNone);      // Unchanged by failed resize
  // Push and pop on array 1
  addEntry(actPush,   1, 0, 12'h011, 12'h000, errNone);
  addEntry(actPush,   1, 0, 12'h022, 12'h000, errNone);
  addEntry(actPush,   1, 0, 12'h033, 12'h000, errNone);
  addEntry(actPush,   1, 0, 12'h044, 12'h000, errNone);
  addEntry(actPush,   1, 0, 12'h055, 12'h000, errFull);
  addEntry(actPop,    1, 0, 12'h000, 12'h044, errNone);      // Last in, first out
  addEntry(actPop,    1, 0, 12'h000, 12'h033, errNone);
  addEntry(actPop,    1, 0, 12'h000, 12'h022, errNone);
  addEntry(actPop,    1, 0, 12'h000, 12'h011, errNone);
  addEntry(actPop,    1, 0, 12'h000, 12'h000, errEmpty);
  // Read-modify-write on element 0 of array 0, starting at 123
  addEntry(actAdd,    0, 0, 12'hF00, 12'h023, errNone);      // Wraps past 4096
  addEntry(actSub,    0, 0, 12'h100, 12'hF23, errNone);      // Wraps below zero
  addEntry(actAnd,    0, 0, 12'h0FF, 12'h023, errNone);
  addEntry(actOr,     0, 0, 12'h500, 12'h523, errNone);
  addEntry(actXor,    0, 0, 12'h0F0, 12'h5D3, errNone);
  addEntry(actRead,   0, 0, 12'h000, 12'h5D3, errNone);
  // Resize within the length
  addEntry(actResize, 3, 0, 12'h004, 12'h000, errNone);
  addEntry(actSize,   3, 0, 12'h000, 12'h004, errNone);
  // Freed, cleared and unknown
  addEntry(actFree,   3, 0, 12'h000, 12'h000, errNone);
  addEntry(actRead,   3, 0, 12'h000, 12'h000, errFreed);
  addEntry(actFree,   3, 0, 12'h000, 12'h000, errFreed);     // Double free refused
  addEntry(actClear,  0, 0, 12'h000, 12'h000, errNone);
  addEntry(actRead,   0, 0, 12'h000, 12'h000, errNotAllocated);
  addEntry(actAlloc,  0, 0, 12'h000, 12'h000, errNone);      // Numbering starts over
  addEntry(5'd31,     0, 0, 12'h000, 12'h000, errBadAction);
endtask

`endif

// ==== verif/heapMemoryTb.sv ====
// --------------------
// Heap memory testbench
// Runs the command table over APB and checks every response
// --------------------
`timescale 1ns/10ps

module heapMemoryTb import heapPkg::*; ();

  localparam int addressBits = 2;
  localparam int indexBits   = 2;
  localparam int dataBits    = 12;
  localparam int addrWidth   = actionBits + addressBits + indexBits;

  logic                 clock;
  logic                 resetN;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [addrWidth-1:0] paddr;
  logic [dataBits-1:0]  pwdata;
  logic [dataBits-1:0]  prdata;
  logic                 pready;
  logic                 pslverr;

  // --------------------
  // Command table
  // --------------------
  logic [actionBits-1:0]  vecAction  [$];
  logic [addressBits-1:0] vecArray   [$];
  logic [indexBits-1:0]   vecIndex   [$];
  logic [dataBits-1:0]    vecOperand [$];
  logic [dataBits-1:0]    vecResult  [$];          // Result, or error code on failure
  logic                   vecSlvErr  [$];
  int                     cycleCount = 0;

  // An error answer carries its code on prdata with pslverr high
  task automatic addEntry(input logic [actionBits-1:0] action, input int array,
                          input int index, input logic [dataBits-1:0] operand,
                          input logic [dataBits-1:0] result, input heapError error);
    vecAction.push_back(action);
    vecArray.push_back(addressBits'(array));
    vecIndex.push_back(indexBits'(index));
    vecOperand.push_back(operand);
    if (error != errNone) begin
      vecResult.push_back(dataBits'(error));
      vecSlvErr.push_back(1'b1);
    end else begin
      vecResult.push_back(result);
      vecSlvErr.push_back(1'b0);
    end
  endtask

  `include "heapVectors.svh"

  heapMemory #(
    .addressBits(addressBits),
    .indexBits  (indexBits),
    .dataBits   (dataBits)
  ) dut0 (
    .clock  (clock),
    .resetN (resetN),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .paddr  (paddr),
    .pwdata (pwdata),
    .prdata (prdata),
    .pready (pready),
    .pslverr(pslverr)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;                     // 10 ns period
  end

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  // Stuck handshake guard
  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > 4 * vecAction.size() + 20) begin
      stopWithFailure("Timeout: the command table did not finish in time");
    end
  end

  // --------------------
  // APB driver and checks
  // --------------------
  task automatic checkResponse(input int n);
    assert (pslverr === vecSlvErr[n])
      else stopWithFailure($sformatf("mismatch at %0t: entry %0d pslverr is %b, expected %b",
                                     $time, n, pslverr, vecSlvErr[n]));
    assert (prdata === vecResult[n])
      else stopWithFailure($sformatf("mismatch at %0t: entry %0d prdata is %h, expected %h",
                                     $time, n, prdata, vecResult[n]));
  endtask

  task automatic runTransfer(input int n);
    int lateCycles;
    lateCycles = 0;
    @(negedge clock);
    psel    = 1'b1;                                // Setup phase
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = {vecAction[n], vecArray[n], vecIndex[n]};
    pwdata  = vecOperand[n];
    @(negedge clock);
    penable = 1'b1;                                // Access phase
    assert (pready === 1'b0)
      else stopWithFailure($sformatf("mismatch at %0t: entry %0d pready is %b, expected 0",
                                     $time, n, pready));
    @(negedge clock);
    while (!pready) begin                          // One wait state expected
      lateCycles++;
      @(negedge clock);
    end
    assert (lateCycles == 0)
      else stopWithFailure($sformatf("pready for entry %0d came %0d cycles late",
                                     n, lateCycles));
    checkResponse(n);
  endtask

  initial begin
    resetN  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    buildTable();
    repeat (4) @(negedge clock);
    resetN = 1'b1;
    for (int i = 0; i < vecAction.size(); i++) begin
      runTransfer(i);
    end
    @(negedge clock);
    psel    = 1'b0;                                // Bus back to idle
    penable = 1'b0;
    $display("Done: no errors");
    $finish;
  end

endmodule
